// ==== include/mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define IMEM_DEPTH  64
`define DMEM_DEPTH  64

// opcodes
`define OP_RTYPE    6'b000000
`define OP_ADDI     6'b001000
`define OP_LW       6'b100011
`define OP_SW       6'b101011
`define OP_BEQ      6'b000100
`define OP_J        6'b000010

// R-format function codes
`define FN_ADD      6'b100000
`define FN_SUB      6'b100010
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_SLT      6'b101010

// ALU operations
`define ALU_AND     4'b0000
`define ALU_OR      4'b0001
`define ALU_ADD     4'b0010
`define ALU_SUB     4'b0110
`define ALU_SLT     4'b0111

`endif

// ==== rtl/mips_pkg.sv ====
`include "mips_consts.svh"

package mips_pkg;

	typedef logic [$clog2(`IMEM_DEPTH)-1:0] imemAddr_t;
	typedef logic [$clog2(`DMEM_DEPTH)-1:0] dmemAddr_t;

	//////////////////////////////////////////////////
	// instruction word, one view per format
	//////////////////////////////////////////////////
	typedef union packed {
		struct packed {
			logic [5:0]             opcode;
			logic [`REG_ADDR_W-1:0] rs;
			logic [`REG_ADDR_W-1:0] rt;
			logic [`REG_ADDR_W-1:0] rd;
			logic [4:0]             shamt;
			logic [5:0]             funct;
		} rFormat;
		struct packed {
			logic [5:0]             opcode;
			logic [`REG_ADDR_W-1:0] rs;
			logic [`REG_ADDR_W-1:0] rt;
			logic [15:0]            imm;
		} iFormat;
		struct packed {
			logic [5:0]  opcode;
			logic [25:0] target;
		} jFormat;
	} instrWord_t;

	typedef enum logic [1:0] {
		aluOpMem    = 2'b00,
		aluOpBranch = 2'b01,
		aluOpRtype  = 2'b10
	} aluOp_t;

	typedef enum logic [1:0] {
		fwdRegFile = 2'b00,
		fwdWb      = 2'b01,
		fwdMem     = 2'b10
	} fwdSel_t;

	typedef struct packed {
		logic   regDst;
		logic   aluSrc;
		aluOp_t aluOp;
		logic   memRead;
		logic   memWrite;
		logic   memToReg;
		logic   regWrite;
	} ctrl_t;

	//////////////////////////////////////////////////
	// pipeline registers
	//////////////////////////////////////////////////
	typedef struct packed {
		logic              valid;
		logic [`XLEN-1:0]  pcPlus4;
		instrWord_t        instr;
	} ifId_t;

	typedef struct packed {
		ctrl_t                  ctrl;
		logic [`XLEN-1:0]       rsVal;
		logic [`XLEN-1:0]       rtVal;
		logic [`XLEN-1:0]       immExt;
		logic [`REG_ADDR_W-1:0] rs;
		logic [`REG_ADDR_W-1:0] rt;
		logic [`REG_ADDR_W-1:0] rd;
	} idEx_t;

	typedef struct packed {
		ctrl_t                  ctrl;
		logic [`XLEN-1:0]       aluResult;
		logic [`XLEN-1:0]       storeData;
		logic [`REG_ADDR_W-1:0] destReg;
	} exMem_t;

	typedef struct packed {
		logic                   regWrite;
		logic                   memToReg;
		logic [`XLEN-1:0]       aluResult;
		logic [`XLEN-1:0]       loadData;
		logic [`REG_ADDR_W-1:0] destReg;
	} memWb_t;

	typedef struct packed {
		logic                   valid;
		logic [`REG_ADDR_W-1:0] destReg;
		logic [`XLEN-1:0]       data;
	} retire_t;

	typedef struct packed {
		logic             valid;
		imemAddr_t        addr;
		logic [`XLEN-1:0] data;
	} imemWrite_t;

	// value written back by an instruction in MEM/WB
	function automatic logic [`XLEN-1:0] wbValue(memWb_t wb);
		return wb.memToReg ? wb.loadData : wb.aluResult;
	endfunction

endpackage

// ==== rtl/fetchStage.sv ====
`include "mips_consts.svh"

module fetchStage import mips_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  imemWrite_t       imemLoad,
	input  logic             stall,
	input  logic             redirect,
	input  logic [`XLEN-1:0] redirectPc,
	output logic [`XLEN-1:0] pc,
	output ifId_t            ifId
);

	logic [`XLEN-1:0] imem [`IMEM_DEPTH];
	logic [`XLEN-1:0] pcPlus4;
	logic [`XLEN-1:0] fetchWord;

	// load port, open even while reset is held
	always_ff @(posedge clk) begin
		if (imemLoad.valid) begin
			imem[imemLoad.addr] <= imemLoad.data;
		end
	end

	assign fetchWord = imem[imemAddr_t'(pc >> 2)];
	assign pcPlus4 = pc + `XLEN'd4;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (!stall) begin
			pc <= redirect ? redirectPc : pcPlus4;
		end
	end

	// IF/ID, a redirect flushes the wrong-path word
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ifId <= '0;
		end else if (stall) begin
			ifId <= ifId;
		end else if (redirect) begin
			ifId <= '0;
		end else begin
			ifId.valid   <= 1'b1;
			ifId.pcPlus4 <= pcPlus4;
			ifId.instr   <= fetchWord;
		end
	end

	imemAddrInRange: assert property (@(posedge clk)
		imemLoad.valid |-> (imemLoad.addr < `IMEM_DEPTH));

endmodule

// ==== rtl/registerFile.sv ====
`include "mips_consts.svh"

module registerFile import mips_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`REG_ADDR_W-1:0] rsAddr,
	input  logic [`REG_ADDR_W-1:0] rtAddr,
	input  memWb_t                 writeBack,
	output logic [`XLEN-1:0]       rsVal,
	output logic [`XLEN-1:0]       rtVal
);

	logic [`XLEN-1:0] regs [32];
	logic             wbActive;

	assign wbActive = writeBack.regWrite && (writeBack.destReg != '0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wbActive) begin
			regs[writeBack.destReg] <= wbValue(writeBack);
		end
	end

	// write-through read, r0 pinned to zero
	function automatic logic [`XLEN-1:0] readPort(logic [`REG_ADDR_W-1:0] addr,
			logic [`XLEN-1:0] stored, logic active, memWb_t wb);
		if (addr == '0) begin
			return '0;
		end else if (active && (wb.destReg == addr)) begin
			return wbValue(wb);
		end
		return stored;
	endfunction

	assign rsVal = readPort(rsAddr, regs[rsAddr], wbActive, writeBack);
	assign rtVal = readPort(rtAddr, regs[rtAddr], wbActive, writeBack);

endmodule

// ==== rtl/mainDecoder.sv ====
`include "mips_consts.svh"

module mainDecoder import mips_pkg::*; (
	input  logic [5:0] opcode,
	output ctrl_t      ctrl,
	output logic       isBranch,
	output logic       isJump
);

	always_comb begin
		ctrl     = '0;
		isBranch = 1'b0;
		isJump   = 1'b0;
		case (opcode)
			`OP_RTYPE: begin
				ctrl.regDst   = 1'b1;
				ctrl.aluOp    = aluOpRtype;
				ctrl.regWrite = 1'b1;
			end
			`OP_ADDI: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluOpMem;
				ctrl.regWrite = 1'b1;
			end
			`OP_LW: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluOpMem;
				ctrl.memRead  = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			`OP_SW: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluOpMem;
				ctrl.memWrite = 1'b1;
			end
			// resolved in decode, nothing left to do downstream
			`OP_BEQ: begin
				ctrl.aluOp = aluOpBranch;
				isBranch   = 1'b1;
			end
			`OP_J: begin
				isJump = 1'b1;
			end
			// unsupported opcode behaves as a nop
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

// ==== rtl/decodeStage.sv ====
`include "mips_consts.svh"

module decodeStage import mips_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  ifId_t            ifId,
	input  exMem_t           exMem,
	input  memWb_t           memWb,
	output idEx_t            idExOut,
	output logic             stall,
	output logic             redirect,
	output logic [`XLEN-1:0] redirectPc
);

	ctrl_t                  ctrlRaw;
	logic                   isBranch;
	logic                   isJump;
	logic [`XLEN-1:0]       rsVal;
	logic [`XLEN-1:0]       rtVal;
	logic [`XLEN-1:0]       immExt;
	logic [`XLEN-1:0]       branchTarget;
	logic [`XLEN-1:0]       jumpTarget;
	logic [`REG_ADDR_W-1:0] rs;
	logic [`REG_ADDR_W-1:0] rt;
	logic [`REG_ADDR_W-1:0] exDest;
	logic                   loadUse;
	logic                   branchWait;
	idEx_t                  idExNext;

	assign rs = ifId.instr.rFormat.rs;
	assign rt = ifId.instr.rFormat.rt;

	registerFile regFile (
		.clk       (clk),
		.reset     (reset),
		.rsAddr    (rs),
		.rtAddr    (rt),
		.writeBack (memWb),
		.rsVal     (rsVal),
		.rtVal     (rtVal)
	);

	mainDecoder decoder (
		.opcode   (ifId.instr.rFormat.opcode),
		.ctrl     (ctrlRaw),
		.isBranch (isBranch),
		.isJump   (isJump)
	);

	assign immExt = {{(`XLEN-16){ifId.instr.iFormat.imm[15]}}, ifId.instr.iFormat.imm};
	assign branchTarget = ifId.pcPlus4 + {immExt[`XLEN-3:0], 2'b00};
	assign jumpTarget = {ifId.pcPlus4[`XLEN-1:28], ifId.instr.jFormat.target, 2'b00};

	//////////////////////////////////////////////////
	// hazard detection
	//////////////////////////////////////////////////
	assign exDest = idExOut.ctrl.regDst ? idExOut.rd : idExOut.rt;

	assign loadUse = idExOut.ctrl.memRead && (idExOut.rt != '0)
		&& ((idExOut.rt == rs) || (idExOut.rt == rt));

	// beq compares in decode, so both producers ahead must drain
	assign branchWait = isBranch && (
		(idExOut.ctrl.regWrite && (exDest != '0) && ((exDest == rs) || (exDest == rt)))
		|| (exMem.ctrl.regWrite && (exMem.destReg != '0)
			&& ((exMem.destReg == rs) || (exMem.destReg == rt))));

	assign stall = ifId.valid && (loadUse || branchWait);

	assign redirect = ifId.valid && !stall
		&& ((isBranch && (rsVal == rtVal)) || isJump);
	assign redirectPc = isJump ? jumpTarget : branchTarget;

	always_comb begin
		idExNext.ctrl   = ifId.valid ? ctrlRaw : '0;
		idExNext.rsVal  = rsVal;
		idExNext.rtVal  = rtVal;
		idExNext.immExt = immExt;
		idExNext.rs     = rs;
		idExNext.rt     = rt;
		idExNext.rd     = ifId.instr.rFormat.rd;
	end

	// ID/EX, bubble while stalled
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			idExOut <= '0;
		end else if (stall) begin
			idExOut <= '0;
		end else begin
			idExOut <= idExNext;
		end
	end

	// the wrong-path slot behind a redirect comes back as a bubble
	redirectFlushesFetch: assert property (@(posedge clk) disable iff (reset)
		redirect |=> !ifId.valid);

endmodule

// ==== rtl/executeStage.sv ====
`include "mips_consts.svh"

module executeStage import mips_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  idEx_t  idEx,
	input  memWb_t memWb,
	output exMem_t exMem
);

	fwdSel_t                fwdA;
	fwdSel_t                fwdB;
	logic [`XLEN-1:0]       opA;
	logic [`XLEN-1:0]       rtFwd;
	logic [`XLEN-1:0]       opB;
	logic [`XLEN-1:0]       aluResult;
	logic [3:0]             aluCtrl;
	logic [5:0]             funct;
	logic [`REG_ADDR_W-1:0] destReg;

	//////////////////////////////////////////////////
	// forwarding
	//////////////////////////////////////////////////
	function automatic fwdSel_t pickSource(logic [`REG_ADDR_W-1:0] src, exMem_t mem,
			memWb_t wb);
		if (src == '0) begin
			return fwdRegFile;
		end else if (mem.ctrl.regWrite && (mem.destReg == src)) begin
			return fwdMem;
		end else if (wb.regWrite && (wb.destReg == src)) begin
			return fwdWb;
		end
		return fwdRegFile;
	endfunction

	function automatic logic [`XLEN-1:0] fwdMux(fwdSel_t sel, logic [`XLEN-1:0] regVal,
			exMem_t mem, memWb_t wb);
		case (sel)
			fwdMem:  return mem.aluResult;
			fwdWb:   return wbValue(wb);
			default: return regVal;
		endcase
	endfunction

	assign fwdA = pickSource(idEx.rs, exMem, memWb);
	assign fwdB = pickSource(idEx.rt, exMem, memWb);
	assign opA = fwdMux(fwdA, idEx.rsVal, exMem, memWb);
	assign rtFwd = fwdMux(fwdB, idEx.rtVal, exMem, memWb);
	assign opB = idEx.ctrl.aluSrc ? idEx.immExt : rtFwd;

	// funct sits in the low immediate bits of an R-format word
	assign funct = idEx.immExt[5:0];

	always_comb begin
		case (idEx.ctrl.aluOp)
			aluOpMem:    aluCtrl = `ALU_ADD;
			aluOpBranch: aluCtrl = `ALU_SUB;
			aluOpRtype: begin
				case (funct)
					`FN_ADD: aluCtrl = `ALU_ADD;
					`FN_SUB: aluCtrl = `ALU_SUB;
					`FN_AND: aluCtrl = `ALU_AND;
					`FN_OR:  aluCtrl = `ALU_OR;
					`FN_SLT: aluCtrl = `ALU_SLT;
					default: aluCtrl = 4'b1111;
				endcase
			end
			default: aluCtrl = 4'b1111;
		endcase
	end

	always_comb begin
		case (aluCtrl)
			`ALU_AND: aluResult = opA & opB;
			`ALU_OR:  aluResult = opA | opB;
			`ALU_ADD: aluResult = opA + opB;
			`ALU_SUB: aluResult = opA - opB;
			`ALU_SLT: aluResult = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
			default:  aluResult = '0;
		endcase
	end

	assign destReg = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			exMem <= '0;
		end else begin
			exMem.ctrl      <= idEx.ctrl;
			exMem.aluResult <= aluResult;
			exMem.storeData <= rtFwd;
			exMem.destReg   <= destReg;
		end
	end

	// anything that writes or touches memory needs a defined operation
	aluOpDefined: assert property (@(posedge clk) disable iff (reset)
		(idEx.ctrl.regWrite || idEx.ctrl.memRead || idEx.ctrl.memWrite)
		|-> aluCtrl inside {`ALU_AND, `ALU_OR, `ALU_ADD, `ALU_SUB, `ALU_SLT});

endmodule

// ==== rtl/memoryStage.sv ====
`include "mips_consts.svh"

module memoryStage import mips_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  exMem_t  exMem,
	output memWb_t  memWb,
	output retire_t retire
);

	logic [`XLEN-1:0] dmem [`DMEM_DEPTH];
	dmemAddr_t        dmemIndex;
	logic [`XLEN-1:0] loadData;

	// word index, byte offset dropped
	assign dmemIndex = dmemAddr_t'(exMem.aluResult >> 2);

	always_ff @(posedge clk) begin
		if (exMem.ctrl.memWrite) begin
			dmem[dmemIndex] <= exMem.storeData;
		end
	end

	assign loadData = exMem.ctrl.memRead ? dmem[dmemIndex] : '0;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			memWb <= '0;
		end else begin
			memWb.regWrite  <= exMem.ctrl.regWrite;
			memWb.memToReg  <= exMem.ctrl.memToReg;
			memWb.aluResult <= exMem.aluResult;
			memWb.loadData  <= loadData;
			memWb.destReg   <= exMem.destReg;
		end
	end

	// retire follows MEM/WB directly
	assign retire.valid   = memWb.regWrite && (memWb.destReg != '0);
	assign retire.destReg = memWb.destReg;
	assign retire.data    = wbValue(memWb);

	memAccessExclusive: assert property (@(posedge clk) disable iff (reset)
		!(exMem.ctrl.memRead && exMem.ctrl.memWrite));

endmodule

// ==== rtl/pipelineCore.sv ====
`include "mips_consts.svh"

module pipelineCore import mips_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  imemWrite_t       imemLoad,
	output retire_t          retire,
	output logic [`XLEN-1:0] pc
);

	ifId_t            ifId;
	idEx_t            idEx;
	exMem_t           exMem;
	memWb_t           memWb;
	logic             stall;
	logic             redirect;
	logic [`XLEN-1:0] redirectPc;

	fetchStage fetch (
		.clk        (clk),
		.reset      (reset),
		.imemLoad   (imemLoad),
		.stall      (stall),
		.redirect   (redirect),
		.redirectPc (redirectPc),
		.pc         (pc),
		.ifId       (ifId)
	);

	decodeStage decode (
		.clk        (clk),
		.reset      (reset),
		.ifId       (ifId),
		.exMem      (exMem),
		.memWb      (memWb),
		.idExOut    (idEx),
		.stall      (stall),
		.redirect   (redirect),
		.redirectPc (redirectPc)
	);

	executeStage execute (
		.clk   (clk),
		.reset (reset),
		.idEx  (idEx),
		.memWb (memWb),
		.exMem (exMem)
	);

	memoryStage memory (
		.clk    (clk),
		.reset  (reset),
		.exMem  (exMem),
		.memWb  (memWb),
		.retire (retire)
	);

endmodule

// ==== dv/pipelineTb.sv ====
`include "mips_consts.svh"

module pipelineTb import mips_pkg::*; ();

	localparam string testDataPath = "dv/pipeline_testdata.txt";

	logic                   clk;
	logic                   reset;
	imemWrite_t             imemLoad;
	retire_t                retire;
	logic [`XLEN-1:0]       pc;

	logic [`XLEN-1:0]       testData [256];
	logic [`REG_ADDR_W-1:0] expReg [$];
	logic [`XLEN-1:0]       expData [$];
	int                     progCount;
	int                     expCount;
	int                     retired;

	pipelineCore DUT (
		.clk      (clk),
		.reset    (reset),
		.imemLoad (imemLoad),
		.retire   (retire),
		.pc       (pc)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	//////////////////////////////////////////////////
	// test data, program words then expected write-backs
	//////////////////////////////////////////////////
	task automatic readTestData();
		int base;
		$readmemh(testDataPath, testData);
		progCount = testData[0];
		assert (progCount > 0 && progCount <= `IMEM_DEPTH) else begin
			abortRun($sformatf("Program word count %0d in the test data is out of range",
				progCount));
		end
		base = progCount + 1;
		expCount = testData[base];
		assert (expCount > 0 && base + 2 * expCount < 256) else begin
			abortRun($sformatf("Expected write-back count %0d in the test data is unusable",
				expCount));
		end
		for (int i = 0; i < expCount; i++) begin
			expReg.push_back(testData[base + 1 + 2 * i][`REG_ADDR_W-1:0]);
			expData.push_back(testData[base + 2 + 2 * i]);
		end
	endtask

	// one word per rising edge, all while reset is held
	task automatic loadProgram();
		for (int i = 0; i < progCount; i++) begin
			@(posedge clk);
			imemLoad.valid <= 1'b1;
			imemLoad.addr  <= imemAddr_t'(i);
			imemLoad.data  <= testData[i + 1];
		end
		@(posedge clk);
		imemLoad <= '0;
	endtask

	task automatic checkRetire();
		logic [`REG_ADDR_W-1:0] wantReg;
		logic [`XLEN-1:0]       wantData;
		wantReg  = expReg[retired];
		wantData = expData[retired];
		assert (retire.destReg === wantReg) else begin
			abortRun($sformatf("Mismatch retire.destReg at write-back %0d: expected 0x%h, got 0x%h",
				retired, wantReg, retire.destReg));
		end
		assert (retire.data === wantData) else begin
			abortRun($sformatf("Mismatch retire.data at write-back %0d: expected 0x%h, got 0x%h",
				retired, wantData, retire.data));
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial begin
		int               resetCycles;
		logic [`XLEN-1:0] parkPc;
		reset    = 1'b1;
		imemLoad = '0;
		retired  = 0;
		readTestData();
		// last program word is the jump to itself
		parkPc = (progCount - 1) * 4;
		loadProgram();
		resetCycles = progCount + 1;
		while (resetCycles < 10) begin
			@(posedge clk);
			resetCycles++;
		end

		// fetch sits at address zero while reset is held
		@(negedge clk);
		assert (pc === '0) else begin
			abortRun($sformatf("Mismatch pc during reset: expected 0x%h, got 0x%h",
				`XLEN'h0, pc));
		end
		@(posedge clk);
		reset <= 1'b0;

		// retire is sampled mid-cycle, away from the edge
		while (retired < expCount) begin
			@(negedge clk);
			if (retire.valid) begin
				checkRetire();
				retired++;
			end
		end

		// program parks in a jump to itself, so nothing else may retire
		repeat (30) begin
			@(negedge clk);
			assert (!retire.valid) else begin
				abortRun($sformatf("Unexpected extra write-back to register %0d with data 0x%h",
					retire.destReg, retire.data));
			end
			assert (pc === parkPc || pc === parkPc + 4) else begin
				abortRun($sformatf("Mismatch pc while parked: expected 0x%h or 0x%h, got 0x%h",
					parkPc, parkPc + 4, pc));
			end
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

	// watchdog, scaled by program length
	initial begin
		@(negedge reset);
		repeat (8 * progCount + 100) @(posedge clk);
		abortRun($sformatf("Retirement stalled: %0d of %0d write-backs seen, pc at 0x%h",
			retired, expCount, pc));
	end

endmodule

// ==== dv/pipeline_testdata.txt ====
// first block: program word count, then one instruction word per line
// second block: expected write-back count, then destination register and data per line
15
20010005 // addi $1, $0, 5
2002FFFD // addi $2, $0, -3
00221820 // add  $3, $1, $2
00612022 // sub  $4, $3, $1
00642824 // and  $5, $3, $4
00233025 // or   $6, $1, $3
0041382A // slt  $7, $2, $1
0022402A // slt  $8, $1, $2
AC060008 // sw   $6, 8($0)
8C090008 // lw   $9, 8($0)
01295020 // add  $10, $9, $9
20200007 // addi $0, $1, 7
00015820 // add  $11, $0, $1
11610001 // beq  $11, $1, +1 (taken)
200C0099 // addi $12, $0, 0x99 (skipped)
10220001 // beq  $1, $2, +1 (not taken)
200D0055 // addi $13, $0, 0x55
08000013 // j    19
200E0077 // addi $14, $0, 0x77 (skipped)
8C0F0008 // lw   $15, 8($0)
08000014 // j    20
0D
01 00000005
02 FFFFFFFD
03 00000002
04 FFFFFFFD
05 00000000
06 00000007
07 00000001
08 00000000
09 00000007
0A 0000000E
0B 00000005
0D 00000055
0F 00000007

// ==== filelist.f ====
+incdir+include
rtl/mips_pkg.sv
rtl/fetchStage.sv
rtl/registerFile.sv
rtl/mainDecoder.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/pipelineCore.sv
dv/pipelineTb.sv
